//--- tb.f
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_memory.sv
rv_core.sv
tb_rv_core.sv

//--- tb_rv_core.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module tb_rv_core;

	localparam int N_ROWS         = 35;
	localparam int TIMEOUT_CYCLES = 3 * N_ROWS + 20;
	localparam int DRAIN_CYCLES   = 8;
	localparam logic [31:0] NOP   = 32'h0000_0013;

	logic                 clk;
	logic                 rst_n;
	logic [`RV_XLEN-1:0]  imem_addr;
	logic [`RV_XLEN-1:0]  imem_data;
	logic                 wb_valid;
	logic [`RV_REG_W-1:0] wb_rd_num;
	logic [`RV_XLEN-1:0]  wb_data;

	// program table, one row per instruction
	logic [31:0]          prog_inst [0:N_ROWS-1];
	logic                 exp_wr    [0:N_ROWS-1];
	logic [`RV_REG_W-1:0] exp_rd    [0:N_ROWS-1];
	logic [`RV_XLEN-1:0]  exp_data  [0:N_ROWS-1];
	int                   n_rows;
	int                   errors;
	int                   cycles;

	rv_core DUT (
		.i_clk(clk), .i_rst_n(rst_n),
		.o_imem_addr(imem_addr), .i_imem_data(imem_data),
		.o_wb_valid(wb_valid), .o_wb_rd_num(wb_rd_num), .o_wb_data(wb_data)
	);

	// instruction memory answers combinationally, nops past the table
	always_comb begin
		if (imem_addr[`RV_XLEN-1:2] < N_ROWS)
			imem_data = prog_inst[imem_addr[`RV_XLEN-1:2]];
		else
			imem_data = NOP;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
	endfunction

	function automatic logic [31:0] op_reg(input logic alt, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [6:0] f7;
		f7 = alt ? rv_isa_pkg::FUNCT7_ALT : 7'b0;
		return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
	endfunction

	function automatic logic [31:0] load_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, rv_isa_pkg::FUNCT3_WORD, rd, rv_isa_pkg::LOAD};
	endfunction

	function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, rv_isa_pkg::FUNCT3_WORD, imm[4:0], rv_isa_pkg::STORE};
	endfunction

	function automatic logic [31:0] upper(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	task automatic add_row(input logic [31:0] inst, input logic wr, input logic [4:0] rd,
		input logic [31:0] data);
		if (n_rows < N_ROWS) begin
			prog_inst[n_rows] = inst;
			exp_wr[n_rows]    = wr;
			exp_rd[n_rows]    = rd;
			exp_data[n_rows]  = data;
		end
		n_rows++;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] observed);
		if (observed !== expected) begin
			$display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, observed);
			errors++;
		end
	endtask

	task automatic wait_writeback;
		do begin
			@(posedge clk);
			#1;
		end while (wb_valid !== 1'b1);
	endtask

	// expected values worked out by hand, x1 = -5 and x2 = 12
	task automatic build_program;
		n_rows = 0;
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd1, 5'd0, 12'hFFB), 1'b1, 5'd1, 32'hFFFF_FFFB);
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd2, 5'd0, 12'h00C), 1'b1, 5'd2, 32'h0000_000C);
		add_row(op_imm(rv_isa_pkg::SLT, 5'd3, 5'd1, 12'hFFC), 1'b1, 5'd3, 32'h0000_0001);
		add_row(op_imm(rv_isa_pkg::SLT, 5'd4, 5'd2, 12'h005), 1'b1, 5'd4, 32'h0000_0000);
		add_row(op_imm(rv_isa_pkg::SLTU, 5'd5, 5'd1, 12'h005), 1'b1, 5'd5, 32'h0000_0000);
		add_row(op_imm(rv_isa_pkg::SLTU, 5'd6, 5'd2, 12'hFFF), 1'b1, 5'd6, 32'h0000_0001);
		add_row(op_imm(rv_isa_pkg::XOR, 5'd7, 5'd2, 12'h0F0), 1'b1, 5'd7, 32'h0000_00FC);
		add_row(op_imm(rv_isa_pkg::OR, 5'd8, 5'd2, 12'h701), 1'b1, 5'd8, 32'h0000_070D);
		add_row(op_imm(rv_isa_pkg::AND, 5'd9, 5'd1, 12'h0FF), 1'b1, 5'd9, 32'h0000_00FB);
		add_row(op_imm(rv_isa_pkg::SLL, 5'd10, 5'd1, 12'h004), 1'b1, 5'd10, 32'hFFFF_FFB0);
		add_row(op_imm(rv_isa_pkg::SRL_SRA, 5'd11, 5'd1, 12'h01C), 1'b1, 5'd11, 32'h0000_000F);
		add_row(op_imm(rv_isa_pkg::SRL_SRA, 5'd12, 5'd1, 12'h401), 1'b1, 5'd12, 32'hFFFF_FFFD);
		add_row(op_reg(1'b0, rv_isa_pkg::ADD_SUB, 5'd13, 5'd1, 5'd2), 1'b1, 5'd13, 32'h7);
		add_row(op_reg(1'b1, rv_isa_pkg::ADD_SUB, 5'd14, 5'd2, 5'd1), 1'b1, 5'd14, 32'h11);
		add_row(op_reg(1'b0, rv_isa_pkg::SLL, 5'd15, 5'd2, 5'd11), 1'b1, 5'd15, 32'h0006_0000);
		add_row(op_reg(1'b0, rv_isa_pkg::SLT, 5'd16, 5'd1, 5'd2), 1'b1, 5'd16, 32'h1);
		add_row(op_reg(1'b0, rv_isa_pkg::SLTU, 5'd17, 5'd1, 5'd2), 1'b1, 5'd17, 32'h0);
		add_row(op_reg(1'b0, rv_isa_pkg::XOR, 5'd18, 5'd1, 5'd2), 1'b1, 5'd18, 32'hFFFF_FFF7);
		add_row(op_reg(1'b0, rv_isa_pkg::SRL_SRA, 5'd19, 5'd1, 5'd3), 1'b1, 5'd19, 32'h7FFF_FFFD);
		add_row(op_reg(1'b1, rv_isa_pkg::SRL_SRA, 5'd20, 5'd1, 5'd3), 1'b1, 5'd20, 32'hFFFF_FFFD);
		add_row(op_reg(1'b0, rv_isa_pkg::OR, 5'd21, 5'd1, 5'd2), 1'b1, 5'd21, 32'hFFFF_FFFF);
		add_row(op_reg(1'b0, rv_isa_pkg::AND, 5'd22, 5'd1, 5'd2), 1'b1, 5'd22, 32'h8);
		add_row(upper(rv_isa_pkg::LUI, 5'd23, 20'h12345), 1'b1, 5'd23, 32'h1234_5000);
		// auipc sits at 0x5c
		add_row(upper(rv_isa_pkg::AUIPC, 5'd24, 20'h00001), 1'b1, 5'd24, 32'h0000_105C);
		// dependent chains at distance one and two
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd25, 5'd0, 12'd100), 1'b1, 5'd25, 32'h64);
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd25, 5'd25, 12'd1), 1'b1, 5'd25, 32'h65);
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd26, 5'd0, 12'd7), 1'b1, 5'd26, 32'h7);
		add_row(op_reg(1'b0, rv_isa_pkg::ADD_SUB, 5'd27, 5'd25, 5'd26), 1'b1, 5'd27, 32'h6C);
		add_row(store_word(5'd27, 5'd0, 12'd16), 1'b0, 5'd0, 32'h0);
		add_row(load_word(5'd28, 5'd0, 12'd16), 1'b1, 5'd28, 32'h6C);
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd29, 5'd28, 12'd1), 1'b1, 5'd29, 32'h6D);
		// write to x0 is dropped, then x0 still reads zero
		add_row(op_imm(rv_isa_pkg::ADD_SUB, 5'd0, 5'd0, 12'd55), 1'b0, 5'd0, 32'h0);
		add_row(op_reg(1'b0, rv_isa_pkg::ADD_SUB, 5'd30, 5'd0, 5'd0), 1'b1, 5'd30, 32'h0);
		// negative store offset, x22 = 8 so address 4
		add_row(store_word(5'd1, 5'd22, 12'hFFC), 1'b0, 5'd0, 32'h0);
		add_row(load_word(5'd31, 5'd0, 12'd4), 1'b1, 5'd31, 32'hFFFF_FFFB);
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: writebacks still missing after %0d cycles", TIMEOUT_CYCLES);
		$display("sim failed");
		$finish;
	end

	initial begin
		errors = 0;
		rst_n  = 1'b0;
		build_program();
		if (n_rows != N_ROWS) begin
			$display("program table holds %0d rows, but %0d were expected", n_rows, N_ROWS);
			errors++;
		end

		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		check_value("reset fetch address", 32'h0, imem_addr);
		check_value("reset writeback strobe", 32'h0, {31'b0, wb_valid});

		// first three fetches never stall
		for (int k = 1; k <= 3; k++) begin
			@(posedge clk);
			#1;
			check_value($sformatf("fetch address %0d", k), 32'(4 * k), imem_addr);
			check_value("early writeback strobe", 32'h0, {31'b0, wb_valid});
		end

		for (int i = 0; i < N_ROWS; i++) begin
			if (exp_wr[i]) begin
				wait_writeback();
				check_value($sformatf("row %0d rd", i), {27'b0, exp_rd[i]}, {27'b0, wb_rd_num});
				check_value($sformatf("row %0d data", i), exp_data[i], wb_data);
			end
		end

		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			#1;
			if (wb_valid) begin
				$display("extra writeback to x%0d with data %h after the last expected result",
					wb_rd_num, wb_data);
				errors++;
			end
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	output logic [`RV_XLEN-1:0]   o_imem_addr,
	input  wire  [`RV_XLEN-1:0]   i_imem_data,
	output logic                  o_wb_valid,
	output logic [`RV_REG_W-1:0]  o_wb_rd_num,
	output logic [`RV_XLEN-1:0]   o_wb_data
);

	logic                 stall;
	logic                 f_valid;
	logic [`RV_XLEN-1:0]  f_pc;
	logic [`RV_XLEN-1:0]  f_inst;

	logic                 d_valid;
	logic [`RV_XLEN-1:0]  d_pc;
	logic [`RV_XLEN-1:0]  d_rs1_val;
	logic [`RV_XLEN-1:0]  d_rs2_val;
	logic [`RV_XLEN-1:0]  d_imm;
	logic [`RV_REG_W-1:0] d_rd_num;
	logic                 d_wr_en;
	rv_ctrl_pkg::alu_op_t d_alu_op;
	rv_ctrl_pkg::src_a_t  d_src_a;
	logic                 d_src_b_imm;
	logic                 d_mem_rd;
	logic                 d_mem_wr;

	logic                 e_valid;
	logic [`RV_REG_W-1:0] e_rd_num;
	logic                 e_wr_en;
	logic [`RV_XLEN-1:0]  e_alu_out;
	logic [`RV_XLEN-1:0]  e_store_data;
	logic                 e_mem_rd;
	logic                 e_mem_wr;

	rv_fetch u_fetch (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_stall(stall),
		.o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
		.o_valid(f_valid), .o_pc(f_pc), .o_inst(f_inst)
	);

	// writeback strobe loops back into the register file
	rv_decode u_decode (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(f_valid), .i_pc(f_pc), .i_inst(f_inst),
		.i_wb_valid(o_wb_valid), .i_wb_rd_num(o_wb_rd_num), .i_wb_data(o_wb_data),
		.i_mem_rd_num(e_rd_num), .i_mem_wr_en(e_wr_en),
		.o_stall(stall), .o_valid(d_valid), .o_pc(d_pc),
		.o_rs1_val(d_rs1_val), .o_rs2_val(d_rs2_val), .o_imm(d_imm),
		.o_rd_num(d_rd_num), .o_wr_en(d_wr_en), .o_alu_op(d_alu_op),
		.o_src_a(d_src_a), .o_src_b_imm(d_src_b_imm),
		.o_mem_rd(d_mem_rd), .o_mem_wr(d_mem_wr)
	);

	rv_execute u_execute (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(d_valid), .i_pc(d_pc),
		.i_rs1_val(d_rs1_val), .i_rs2_val(d_rs2_val), .i_imm(d_imm),
		.i_rd_num(d_rd_num), .i_wr_en(d_wr_en), .i_alu_op(d_alu_op),
		.i_src_a(d_src_a), .i_src_b_imm(d_src_b_imm),
		.i_mem_rd(d_mem_rd), .i_mem_wr(d_mem_wr),
		.o_valid(e_valid), .o_rd_num(e_rd_num), .o_wr_en(e_wr_en),
		.o_alu_out(e_alu_out), .o_store_data(e_store_data),
		.o_mem_rd(e_mem_rd), .o_mem_wr(e_mem_wr)
	);

	rv_memory u_memory (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(e_valid), .i_rd_num(e_rd_num), .i_wr_en(e_wr_en),
		.i_alu_out(e_alu_out), .i_store_data(e_store_data),
		.i_mem_rd(e_mem_rd), .i_mem_wr(e_mem_wr),
		.o_wb_valid(o_wb_valid), .o_wb_rd_num(o_wb_rd_num), .o_wb_data(o_wb_data)
	);

endmodule

`default_nettype wire

//--- rv_memory.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_memory (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_valid,
	input  wire  [`RV_REG_W-1:0]  i_rd_num,
	input  wire                   i_wr_en,
	input  wire  [`RV_XLEN-1:0]   i_alu_out,
	input  wire  [`RV_XLEN-1:0]   i_store_data,
	input  wire                   i_mem_rd,
	input  wire                   i_mem_wr,
	output logic                  o_wb_valid,
	output logic [`RV_REG_W-1:0]  o_wb_rd_num,
	output logic [`RV_XLEN-1:0]   o_wb_data
);

	logic [`RV_XLEN-1:0]    dmem [0:(1<<`RV_DMEM_AW)-1];
	logic [`RV_DMEM_AW-1:0] word_addr;
	logic [`RV_XLEN-1:0]    load_data;
	logic [`RV_XLEN-1:0]    result;

	// word index from byte address
	assign word_addr = i_alu_out[`RV_DMEM_AW+1:2];

	always_ff @(posedge i_clk) begin
		if (i_valid && i_mem_wr)
			dmem[word_addr] <= i_store_data;
	end

	assign load_data = dmem[word_addr];
	assign result    = i_mem_rd ? load_data : i_alu_out;

	// writeback strobe, wr_en already excludes x0 and stores
	always_ff @(posedge i_clk) begin
		if (!i_rst_n)
			o_wb_valid <= 1'b0;
		else
			o_wb_valid <= i_valid && i_wr_en;
	end

	always_ff @(posedge i_clk) begin
		o_wb_rd_num <= i_rd_num;
		o_wb_data   <= result;
	end

	a_word_access: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(i_valid && (i_mem_rd || i_mem_wr)) |-> (i_alu_out[1:0] == 2'b00)
	);

endmodule

`default_nettype wire

//--- rv_execute.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_execute (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_valid,
	input  wire  [`RV_XLEN-1:0]   i_pc,
	input  wire  [`RV_XLEN-1:0]   i_rs1_val,
	input  wire  [`RV_XLEN-1:0]   i_rs2_val,
	input  wire  [`RV_XLEN-1:0]   i_imm,
	input  wire  [`RV_REG_W-1:0]  i_rd_num,
	input  wire                   i_wr_en,
	input  wire rv_ctrl_pkg::alu_op_t i_alu_op,
	input  wire rv_ctrl_pkg::src_a_t  i_src_a,
	input  wire                   i_src_b_imm,
	input  wire                   i_mem_rd,
	input  wire                   i_mem_wr,
	output logic                  o_valid,
	output logic [`RV_REG_W-1:0]  o_rd_num,
	output logic                  o_wr_en,
	output logic [`RV_XLEN-1:0]   o_alu_out,
	output logic [`RV_XLEN-1:0]   o_store_data,
	output logic                  o_mem_rd,
	output logic                  o_mem_wr
);

	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [4:0]          shamt;
	logic [`RV_XLEN-1:0] alu_out;

	always_comb begin
		case (i_src_a)
			rv_ctrl_pkg::SRC_A_PC:   op_a = i_pc;
			rv_ctrl_pkg::SRC_A_ZERO: op_a = '0;
			default:                 op_a = i_rs1_val;
		endcase
		op_b  = i_src_b_imm ? i_imm : i_rs2_val;
		shamt = op_b[4:0];
		case (i_alu_op)
			rv_ctrl_pkg::ALU_SUB:  alu_out = op_a - op_b;
			rv_ctrl_pkg::ALU_SLL:  alu_out = op_a << shamt;
			rv_ctrl_pkg::ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			rv_ctrl_pkg::ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
			rv_ctrl_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
			rv_ctrl_pkg::ALU_SRL:  alu_out = op_a >> shamt;
			rv_ctrl_pkg::ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> shamt);
			rv_ctrl_pkg::ALU_OR:   alu_out = op_a | op_b;
			rv_ctrl_pkg::ALU_AND:  alu_out = op_a & op_b;
			// add, also the address for loads and stores
			default:               alu_out = op_a + op_b;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid  <= 1'b0;
			o_wr_en  <= 1'b0;
			o_mem_rd <= 1'b0;
			o_mem_wr <= 1'b0;
		end else begin
			o_valid  <= i_valid;
			o_wr_en  <= i_valid && i_wr_en;
			o_mem_rd <= i_valid && i_mem_rd;
			o_mem_wr <= i_valid && i_mem_wr;
		end
	end

	always_ff @(posedge i_clk) begin
		o_rd_num     <= i_rd_num;
		o_alu_out    <= alu_out;
		o_store_data <= i_rs2_val;
	end

	// decode sets at most one memory flag per instruction
	a_one_mem_op: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(o_mem_rd && o_mem_wr)
	);

endmodule

`default_nettype wire

//--- rv_decode.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_decode (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_valid,
	input  wire  [`RV_XLEN-1:0]   i_pc,
	input  wire  [`RV_XLEN-1:0]   i_inst,
	input  wire                   i_wb_valid,
	input  wire  [`RV_REG_W-1:0]  i_wb_rd_num,
	input  wire  [`RV_XLEN-1:0]   i_wb_data,
	input  wire  [`RV_REG_W-1:0]  i_mem_rd_num,
	input  wire                   i_mem_wr_en,
	output logic                  o_stall,
	output logic                  o_valid,
	output logic [`RV_XLEN-1:0]   o_pc,
	output logic [`RV_XLEN-1:0]   o_rs1_val,
	output logic [`RV_XLEN-1:0]   o_rs2_val,
	output logic [`RV_XLEN-1:0]   o_imm,
	output logic [`RV_REG_W-1:0]  o_rd_num,
	output logic                  o_wr_en,
	output rv_ctrl_pkg::alu_op_t  o_alu_op,
	output rv_ctrl_pkg::src_a_t   o_src_a,
	output logic                  o_src_b_imm,
	output logic                  o_mem_rd,
	output logic                  o_mem_wr
);

	rv_isa_pkg::opcode_t   opcode;
	logic [`RV_REG_W-1:0]  rd;
	logic [`RV_REG_W-1:0]  rs1;
	logic [`RV_REG_W-1:0]  rs2;
	logic [2:0]            funct3;
	logic                  f7_alt;
	logic [`RV_XLEN-1:0]   imm_i;
	logic [`RV_XLEN-1:0]   imm_s;
	logic [`RV_XLEN-1:0]   imm_u;

	rv_ctrl_pkg::alu_op_t  dec_alu_op;
	rv_ctrl_pkg::src_a_t   dec_src_a;
	logic                  dec_src_b_imm;
	logic [`RV_XLEN-1:0]   dec_imm;
	logic                  dec_wr;
	logic                  dec_mem_rd;
	logic                  dec_mem_wr;
	logic                  use_rs1;
	logic                  use_rs2;

	logic [`RV_XLEN-1:0]   regs [0:(1<<`RV_REG_W)-1];
	logic [`RV_XLEN-1:0]   rs1_val;
	logic [`RV_XLEN-1:0]   rs2_val;
	logic                  rs1_hit;
	logic                  rs2_hit;
	logic                  issue;

	function automatic rv_ctrl_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
		rv_ctrl_pkg::alu_op_t op;
		case (f3)
			rv_isa_pkg::ADD_SUB: op = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
			rv_isa_pkg::SLL:     op = rv_ctrl_pkg::ALU_SLL;
			rv_isa_pkg::SLT:     op = rv_ctrl_pkg::ALU_SLT;
			rv_isa_pkg::SLTU:    op = rv_ctrl_pkg::ALU_SLTU;
			rv_isa_pkg::XOR:     op = rv_ctrl_pkg::ALU_XOR;
			rv_isa_pkg::SRL_SRA: op = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
			rv_isa_pkg::OR:      op = rv_ctrl_pkg::ALU_OR;
			default:             op = rv_ctrl_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = rv_isa_pkg::opcode_t'(i_inst[6:0]);
	assign rd     = i_inst[11:7];
	assign funct3 = i_inst[14:12];
	assign rs1    = i_inst[19:15];
	assign rs2    = i_inst[24:20];
	assign f7_alt = (i_inst[31:25] == rv_isa_pkg::FUNCT7_ALT);

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_u = {i_inst[31:12], 12'b0};

	always_comb begin
		dec_alu_op    = rv_ctrl_pkg::ALU_ADD;
		dec_src_a     = rv_ctrl_pkg::SRC_A_REG;
		dec_src_b_imm = 1'b0;
		dec_imm       = imm_i;
		dec_wr        = 1'b0;
		dec_mem_rd    = 1'b0;
		dec_mem_wr    = 1'b0;
		use_rs1       = 1'b0;
		use_rs2       = 1'b0;
		case (opcode)
			rv_isa_pkg::OP: begin
				dec_alu_op = alu_sel(funct3, f7_alt);
				dec_wr     = 1'b1;
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
			end
			rv_isa_pkg::OP_IMM: begin
				// imm bit 30 only means SRAI on the shift-right encoding
				dec_alu_op    = alu_sel(funct3, f7_alt && funct3 == rv_isa_pkg::SRL_SRA);
				dec_src_b_imm = 1'b1;
				dec_wr        = 1'b1;
				use_rs1       = 1'b1;
			end
			rv_isa_pkg::LUI: begin
				dec_src_a     = rv_ctrl_pkg::SRC_A_ZERO;
				dec_src_b_imm = 1'b1;
				dec_imm       = imm_u;
				dec_wr        = 1'b1;
			end
			rv_isa_pkg::AUIPC: begin
				dec_src_a     = rv_ctrl_pkg::SRC_A_PC;
				dec_src_b_imm = 1'b1;
				dec_imm       = imm_u;
				dec_wr        = 1'b1;
			end
			rv_isa_pkg::LOAD: begin
				if (funct3 == rv_isa_pkg::FUNCT3_WORD) begin
					dec_src_b_imm = 1'b1;
					dec_wr        = 1'b1;
					dec_mem_rd    = 1'b1;
					use_rs1       = 1'b1;
				end
			end
			rv_isa_pkg::STORE: begin
				if (funct3 == rv_isa_pkg::FUNCT3_WORD) begin
					dec_src_b_imm = 1'b1;
					dec_imm       = imm_s;
					dec_mem_wr    = 1'b1;
					use_rs1       = 1'b1;
					use_rs2       = 1'b1;
				end
			end
			// anything else retires as a no-op
			default: ;
		endcase
	end

	// register file with the writeback strobe bypassed into the read
	always_ff @(posedge i_clk) begin
		if (i_wb_valid && i_wb_rd_num != '0)
			regs[i_wb_rd_num] <= i_wb_data;
	end

	assign rs1_val = (rs1 == '0) ? '0 :
		(i_wb_valid && i_wb_rd_num == rs1) ? i_wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(i_wb_valid && i_wb_rd_num == rs2) ? i_wb_data : regs[rs2];

	// interlock against execute and memory since the bypass covers writeback
	assign rs1_hit = use_rs1 && rs1 != '0 &&
		((o_wr_en && o_rd_num == rs1) || (i_mem_wr_en && i_mem_rd_num == rs1));
	assign rs2_hit = use_rs2 && rs2 != '0 &&
		((o_wr_en && o_rd_num == rs2) || (i_mem_wr_en && i_mem_rd_num == rs2));

	assign o_stall = i_valid && (rs1_hit || rs2_hit);
	assign issue   = i_valid && !o_stall;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid  <= 1'b0;
			o_wr_en  <= 1'b0;
			o_mem_rd <= 1'b0;
			o_mem_wr <= 1'b0;
		end else begin
			o_valid  <= issue;
			o_wr_en  <= issue && dec_wr && rd != '0;
			o_mem_rd <= issue && dec_mem_rd;
			o_mem_wr <= issue && dec_mem_wr;
		end
	end

	always_ff @(posedge i_clk) begin
		o_pc        <= i_pc;
		o_rs1_val   <= rs1_val;
		o_rs2_val   <= rs2_val;
		o_imm       <= dec_imm;
		o_rd_num    <= rd;
		o_alu_op    <= dec_alu_op;
		o_src_a     <= dec_src_a;
		o_src_b_imm <= dec_src_b_imm;
	end

	// destinations the interlock compares against never name x0
	a_stall_not_x0: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_stall |-> (!o_wr_en || o_rd_num != '0) && (!i_mem_wr_en || i_mem_rd_num != '0)
	);

	// a bubble reaches the memory stage without a write enable
	a_bubble_quiet: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!o_valid |=> !i_mem_wr_en
	);

endmodule

`default_nettype wire

//--- rv_fetch.sv
`default_nettype none
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_fetch (
	input  wire                 i_clk,
	input  wire                 i_rst_n,
	input  wire                 i_stall,
	output logic [`RV_XLEN-1:0] o_imem_addr,
	input  wire  [`RV_XLEN-1:0] i_imem_data,
	output logic                o_valid,
	output logic [`RV_XLEN-1:0] o_pc,
	output logic [`RV_XLEN-1:0] o_inst
);

	logic [`RV_XLEN-1:0] pc_q;

	// instruction memory answers in the same cycle
	assign o_imem_addr = pc_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			pc_q    <= `RV_RESET_PC;
			o_valid <= 1'b0;
		end else if (!i_stall) begin
			pc_q    <= pc_q + `RV_XLEN'(4);
			o_valid <= 1'b1;
		end
	end

	// fetch/decode payload
	always_ff @(posedge i_clk) begin
		if (!i_stall) begin
			o_pc   <= pc_q;
			o_inst <= i_imem_data;
		end
	end

	// no branches, so the pc can never leave word alignment
	a_pc_aligned: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_valid |-> (o_pc[1:0] == 2'b00 && pc_q[1:0] == 2'b00)
	);

endmodule

`default_nettype wire

//--- rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_t;

	// first alu operand
	typedef enum logic [1:0] {
		SRC_A_REG,
		SRC_A_PC,
		SRC_A_ZERO
	} src_a_t;

endpackage

`default_nettype wire

//--- rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_t;

	// funct3 for OP and OP-IMM
	localparam logic [2:0] ADD_SUB = 3'b000;
	localparam logic [2:0] SLL     = 3'b001;
	localparam logic [2:0] SLT     = 3'b010;
	localparam logic [2:0] SLTU    = 3'b011;
	localparam logic [2:0] XOR     = 3'b100;
	localparam logic [2:0] SRL_SRA = 3'b101;
	localparam logic [2:0] OR      = 3'b110;
	localparam logic [2:0] AND     = 3'b111;

	// funct3 of LW and SW
	localparam logic [2:0] FUNCT3_WORD = 3'b010;

	// funct7 that turns ADD into SUB and SRL into SRA
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

`default_nettype wire

//--- rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data and address width
`define RV_XLEN 32

// register index width
`define RV_REG_W 5

// data memory word address width, 64 words
`define RV_DMEM_AW 6

`define RV_RESET_PC 32'h0000_0000

`endif
